// File: design/fmul_ctrl.sv
// Multiplier controller
// Four-phase req/ack FSM, operand and mode capture, per-stage enables

`timescale 1ns/1ps

module fmul_ctrl (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      req,
  input  fp_format_pkg::fp_word_u   operand_a,
  input  fp_format_pkg::fp_word_u   operand_b,
  input  logic                      fmt,            // 1 double, 0 single
  input  fmul_ctrl_pkg::round_mode_e rounding_mode,
  output logic                      ack,
  output logic                      unpack_en,
  output logic                      mult_en,
  output logic                      round_en,
  output fp_format_pkg::fp_word_u   op_a_q,
  output fp_format_pkg::fp_word_u   op_b_q,
  output logic                      fmt_q,
  output fmul_ctrl_pkg::round_mode_e rm_q
);

  import fmul_ctrl_pkg::*;

  fmul_state_e state;

  // ==============================
  // Sequencer
  // ==============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= st_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        st_idle:   if (req) state <= st_unpack;  // Only one op in flight
        st_unpack: state <= st_mult;
        st_mult:   state <= st_round;
        st_round:  state <= st_ack;              // Result is registered on this edge
        st_ack: begin
          if (!ack) begin
            ack <= 1'b1;                          // Result and flags valid from here
          end else if (!req) begin
            ack   <= 1'b0;                        // Requester released, close handshake
            state <= st_idle;
          end
        end
        default:   state <= st_idle;
      endcase
    end
  end

  // One enable per stage, one cycle each
  assign unpack_en = (state == st_unpack);
  assign mult_en   = (state == st_mult);
  assign round_en  = (state == st_round);

  // Inputs held by the requester while req is high, captured once at start
  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      op_a_q <= operand_a;
      op_b_q <= operand_b;
      fmt_q  <= fmt;
      rm_q   <= rounding_mode;
    end
  end

endmodule

// File: design/fmul_ctrl_pkg.sv
// Rounding-mode encoding of the frm field
// State encoding of the multiplier controller

package fmul_ctrl_pkg;

  // Codes 5 to 7 are reserved and handled as RTZ
  typedef enum logic [2:0] {
    rm_rne = 3'd0,  // Nearest, ties to even
    rm_rtz = 3'd1,  // Toward zero
    rm_rdn = 3'd2,  // Toward minus infinity
    rm_rup = 3'd3,  // Toward plus infinity
    rm_rmm = 3'd4   // Nearest, ties away from zero
  } round_mode_e;

  // One state per datapath stage, then the ack phase
  typedef enum logic [2:0] {
    st_idle,
    st_unpack,
    st_mult,
    st_round,
    st_ack
  } fmul_state_e;

endpackage

// File: design/fmul_mant_mul.sv
// Multiply stage
// 53x53 significand product and biased result exponent

`timescale 1ns/1ps

module fmul_mant_mul (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              mult_en,
  input  logic                              fmt,
  input  logic [10:0]                       exp_a,
  input  logic [10:0]                       exp_b,
  input  logic [fp_format_pkg::sig_w-1:0]   sig_a,
  input  logic [fp_format_pkg::sig_w-1:0]   sig_b,
  input  logic                              sign_r,
  input  fp_format_pkg::fp_special_e        special,
  output logic [fp_format_pkg::prod_w-1:0]  product,
  output logic signed [12:0]                exp_sum,
  output logic                              sign_q,
  output fp_format_pkg::fp_special_e        special_q
);

  import fp_format_pkg::*;

  logic [12:0] bias;

  assign bias = fmt ? 13'(bias_d) : 13'(bias_s);

  // Class travels with the data, reset so a stale class never leaks
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) special_q <= sp_none;
    else if (mult_en) special_q <= special;
  end

  always_ff @(posedge clk) begin
    if (mult_en) begin
      product <= prod_w'(sig_a) * prod_w'(sig_b);  // Value in [1,4) with 104 fraction bits
      exp_sum <= {2'b00, exp_a} + {2'b00, exp_b} - bias;  // Normal operands give -1021 .. 3069
      sign_q  <= sign_r;
    end
  end

endmodule

// File: design/fmul_round_pack.sv
// Round and pack stage
// Normalize, guard/round/sticky, five rounding modes, range check, flags

`timescale 1ns/1ps

module fmul_round_pack (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              round_en,
  input  logic                              fmt,
  input  fmul_ctrl_pkg::round_mode_e        rm,
  input  logic [fp_format_pkg::prod_w-1:0]  product,
  input  logic signed [12:0]                exp_sum,
  input  logic                              sign_q,
  input  fp_format_pkg::fp_special_e        special_q,
  output fp_format_pkg::fp_word_u           result,
  output logic                              flag_nv,
  output logic                              flag_of,
  output logic                              flag_uf,
  output logic                              flag_nx
);

  import fp_format_pkg::*;
  import fmul_ctrl_pkg::*;

  logic                 norm;         // Product at or above 2.0
  logic [prod_w-1:0]    prod_n;       // Hidden one at the top bit
  logic signed [12:0]   exp_n, exp_f;
  logic signed [12:0]   exp_lim;
  logic [man_w_d:0]     frac_d_r;     // Extra bit catches the rounding carry
  logic [man_w_s:0]     frac_s_r;
  logic                 g, r, s, lsb;
  logic                 round_up, carry;
  logic                 inexact;
  logic [10:0]          exp_top;
  fp_word_u             w_norm, w_inf, w_zero, w_nan;

  // Builds a result word, single fraction taken from the top 23 bits of m
  function automatic fp_word_u pack_word(input logic f, input logic sg,
                                         input logic [10:0] e, input logic [51:0] m);
    fp_word_u w;
    if (f) begin
      w.dbl.sign = sg;
      w.dbl.exp  = e;
      w.dbl.frac = m;
    end else begin
      w.sgl.box  = '1;                 // NaN boxing
      w.sgl.sign = sg;
      w.sgl.exp  = e[7:0];
      w.sgl.frac = m[51:29];
    end
    return w;
  endfunction

  // ==============================
  // Normalize
  // ==============================
  assign norm   = product[prod_w-1];
  assign prod_n = norm ? product : {product[prod_w-2:0], 1'b0};
  assign exp_n  = exp_sum + {12'd0, norm};

  // Guard, round, sticky sit right below the fraction of the format
  always_comb begin
    if (fmt) begin
      g   = prod_n[prod_w-2-man_w_d];
      r   = prod_n[prod_w-3-man_w_d];
      s   = |prod_n[prod_w-4-man_w_d:0];
      lsb = prod_n[prod_w-1-man_w_d];
    end else begin
      g   = prod_n[prod_w-2-man_w_s];
      r   = prod_n[prod_w-3-man_w_s];
      s   = |prod_n[prod_w-4-man_w_s:0];
      lsb = prod_n[prod_w-1-man_w_s];
    end
  end

  assign inexact = g | r | s;

  // ==============================
  // Rounding decision
  // ==============================
  always_comb begin
    case (rm)
      rm_rne:  round_up = g && (r || s || lsb);   // Tie goes to even
      rm_rtz:  round_up = 1'b0;
      rm_rdn:  round_up = sign_q && inexact;
      rm_rup:  round_up = !sign_q && inexact;
      rm_rmm:  round_up = g;                      // Tie goes away from zero
      default: round_up = 1'b0;                   // Reserved codes truncate
    endcase
  end

  assign frac_d_r = {1'b0, prod_n[prod_w-2 -: man_w_d]} + {{man_w_d{1'b0}}, round_up};
  assign frac_s_r = {1'b0, prod_n[prod_w-2 -: man_w_s]} + {{man_w_s{1'b0}}, round_up};
  assign carry    = fmt ? frac_d_r[man_w_d] : frac_s_r[man_w_s];  // Fraction wrapped to 0
  assign exp_f    = exp_n + {12'd0, carry};

  assign exp_top = fmt ? 11'(exp_max_d) : 11'(exp_max_s);
  assign exp_lim = {2'b00, exp_top};

  // Candidate results
  assign w_norm = pack_word(fmt, sign_q, exp_f[10:0],
                            fmt ? frac_d_r[man_w_d-1:0]
                                : {frac_s_r[man_w_s-1:0], {(man_w_d-man_w_s){1'b0}}});
  assign w_inf  = pack_word(fmt, sign_q, exp_top, '0);
  assign w_zero = pack_word(fmt, sign_q, '0, '0);
  assign w_nan  = fmt ? qnan_d : qnan_s_boxed;

  // ==============================
  // Output register
  // ==============================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      result  <= '0;
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_uf <= 1'b0;
      flag_nx <= 1'b0;
    end else if (round_en) begin
      flag_nv <= 1'b0;
      flag_of <= 1'b0;
      flag_uf <= 1'b0;
      flag_nx <= 1'b0;
      case (special_q)
        sp_nan: begin
          result  <= w_nan;
          flag_nv <= 1'b1;
        end
        sp_inf:  result <= w_inf;     // Exact, no flags
        sp_zero: result <= w_zero;
        default: begin
          if (exp_f >= exp_lim) begin
            result  <= w_inf;           // Overflow to signed infinity
            flag_of <= 1'b1;
            flag_nx <= 1'b1;
          end else if (exp_f < 13'sd1) begin
            result  <= w_zero;          // Below normal range, flushed
            flag_uf <= 1'b1;
            flag_nx <= 1'b1;
          end else begin
            result  <= w_norm;
            flag_nx <= inexact;
          end
        end
      endcase
    end
  end

endmodule

// File: design/fmul_top.sv
// FMUL.S / FMUL.D top level
// Controller plus unpack, multiply and round/pack stages

`timescale 1ns/1ps

module fmul_top (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       req,
  output logic                       ack,
  input  fp_format_pkg::fp_word_u    operand_a,
  input  fp_format_pkg::fp_word_u    operand_b,
  input  logic                       fmt,
  input  fmul_ctrl_pkg::round_mode_e rounding_mode,
  output fp_format_pkg::fp_word_u    result,
  output logic                       flag_nv,
  output logic                       flag_of,
  output logic                       flag_uf,
  output logic                       flag_nx
);

  import fp_format_pkg::*;
  import fmul_ctrl_pkg::*;

  // Controller outputs
  logic              unpack_en, mult_en, round_en;
  fp_word_u          op_a_q, op_b_q;
  logic              fmt_q;
  round_mode_e       rm_q;

  // Unpack to multiply
  logic              sign_r;
  logic [10:0]       exp_a, exp_b;
  logic [sig_w-1:0]  sig_a, sig_b;
  fp_special_e       special;

  // Multiply to round
  logic [prod_w-1:0] product;
  logic signed [12:0] exp_sum;
  logic              sign_q;
  fp_special_e       special_q;

  fmul_ctrl u_ctrl (
    .clk, .reset_n, .req, .operand_a, .operand_b, .fmt, .rounding_mode,
    .ack, .unpack_en, .mult_en, .round_en, .op_a_q, .op_b_q, .fmt_q, .rm_q
  );

  fmul_unpack u_unpack (
    .clk, .reset_n, .unpack_en,
    .op_a (op_a_q),
    .op_b (op_b_q),
    .fmt  (fmt_q),
    .sign_r, .exp_a, .exp_b, .sig_a, .sig_b, .special
  );

  fmul_mant_mul u_mul (
    .clk, .reset_n, .mult_en,
    .fmt  (fmt_q),
    .exp_a, .exp_b, .sig_a, .sig_b, .sign_r, .special,
    .product, .exp_sum, .sign_q, .special_q
  );

  fmul_round_pack u_round (
    .clk, .reset_n, .round_en,
    .fmt  (fmt_q),
    .rm   (rm_q),
    .product, .exp_sum, .sign_q, .special_q,
    .result, .flag_nv, .flag_of, .flag_uf, .flag_nx
  );

endmodule

// File: design/fmul_unpack.sv
// Operand unpack stage
// Field extraction per format, special-value class, significand alignment

`timescale 1ns/1ps

module fmul_unpack (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              unpack_en,
  input  fp_format_pkg::fp_word_u           op_a,
  input  fp_format_pkg::fp_word_u           op_b,
  input  logic                              fmt,
  output logic                              sign_r,
  output logic [10:0]                       exp_a,
  output logic [10:0]                       exp_b,
  output logic [fp_format_pkg::sig_w-1:0]   sig_a,
  output logic [fp_format_pkg::sig_w-1:0]   sig_b,
  output fp_format_pkg::fp_special_e        special
);

  import fp_format_pkg::*;

  logic [10:0]      ea, eb;
  logic [10:0]      exp_top;          // All-ones exponent of the format
  logic             za, zb;           // Zero or subnormal
  logic             ia, ib;           // Infinity
  logic             na, nb;           // NaN, signalling or quiet
  fp_special_e      special_d;

  // Single exponent widened to 11 bits, no rebias here
  function automatic logic [10:0] get_exp(input fp_word_u w, input logic f);
    return f ? w.dbl.exp : {3'b000, w.sgl.exp};
  endfunction

  function automatic logic frac_zero(input fp_word_u w, input logic f);
    return f ? (w.dbl.frac == '0) : (w.sgl.frac == '0);
  endfunction

  // Hidden one at bit 52, single fraction padded below to the same point
  function automatic logic [sig_w-1:0] get_sig(input fp_word_u w, input logic f);
    return f ? {1'b1, w.dbl.frac} : {1'b1, w.sgl.frac, {(sig_w-man_w_s-1){1'b0}}};
  endfunction

  assign exp_top = fmt ? 11'(exp_max_d) : 11'(exp_max_s);
  assign ea = get_exp(op_a, fmt);
  assign eb = get_exp(op_b, fmt);

  assign za = (ea == '0);             // Subnormals flush to zero
  assign zb = (eb == '0);
  assign ia = (ea == exp_top) &&  frac_zero(op_a, fmt);
  assign ib = (eb == exp_top) &&  frac_zero(op_b, fmt);
  assign na = (ea == exp_top) && !frac_zero(op_a, fmt);
  assign nb = (eb == exp_top) && !frac_zero(op_b, fmt);

  // Priority: NaN, zero times inf, inf, zero
  always_comb begin
    if (na || nb)                    special_d = sp_nan;
    else if ((ia && zb) || (za && ib)) special_d = sp_nan;   // Invalid
    else if (ia || ib)               special_d = sp_inf;
    else if (za || zb)               special_d = sp_zero;
    else                             special_d = sp_none;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) special <= sp_none;
    else if (unpack_en) special <= special_d;
  end

  always_ff @(posedge clk) begin
    if (unpack_en) begin
      sign_r <= fmt ? (op_a.dbl.sign ^ op_b.dbl.sign) : (op_a.sgl.sign ^ op_b.sgl.sign);
      exp_a  <= ea;
      exp_b  <= eb;
      sig_a  <= get_sig(op_a, fmt);
      sig_b  <= get_sig(op_b, fmt);
    end
  end

endmodule

// File: design/fp_format_pkg.sv
// IEEE 754 binary64 and binary32 field widths, biases and exponent limits
// Canonical quiet NaNs, double or boxed single
// Operand word union and special-value class

package fp_format_pkg;

  // ==============================
  // Widths and biases
  // ==============================
  localparam int xlen      = 64;    // Register width
  localparam int exp_w_d   = 11;
  localparam int exp_w_s   = 8;
  localparam int man_w_d   = 52;    // Stored fraction bits
  localparam int man_w_s   = 23;
  localparam int bias_d    = 1023;
  localparam int bias_s    = 127;
  localparam int exp_max_d = 2047;  // All-ones exponent, inf or NaN
  localparam int exp_max_s = 255;
  localparam int sig_w     = 53;    // Hidden one plus double fraction
  localparam int prod_w    = 106;   // Full significand product

  // Canonical quiet NaNs
  localparam logic [xlen-1:0] qnan_d       = 64'h7FF8_0000_0000_0000;
  localparam logic [xlen-1:0] qnan_s_boxed = 64'hFFFF_FFFF_7FC0_0000;  // Upper half all ones

  // ==============================
  // Operand word
  // ==============================
  // Same 64 bits, read as a double or as a NaN-boxed single
  typedef union packed {
    struct packed {
      logic               sign;
      logic [exp_w_d-1:0] exp;
      logic [man_w_d-1:0] frac;
    } dbl;
    struct packed {
      logic [31:0]        box;   // All ones for a valid boxed single
      logic               sign;
      logic [exp_w_s-1:0] exp;
      logic [man_w_s-1:0] frac;
    } sgl;
  } fp_word_u;

  // Special class of a multiply, sp_nan also stands for zero times infinity
  typedef enum logic [1:0] {
    sp_none,
    sp_nan,
    sp_inf,
    sp_zero
  } fp_special_e;

endpackage

// File: flist.f
design/fp_format_pkg.sv
design/fmul_ctrl_pkg.sv
design/fmul_ctrl.sv
design/fmul_unpack.sv
design/fmul_mant_mul.sv
design/fmul_round_pack.sv
design/fmul_top.sv
sim/tb_clock_gen.sv
sim/fmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the FMUL testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module fmul_tb \
  -f flist.f \
  -o fmul_sim

out=$(./obj_dir/fmul_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
else
  exit 1
fi

// File: sim/fmul_tb.sv
// Directed and random testbench for the FMUL.S / FMUL.D multiplier
// Four-phase req/ack driver, word and flag compare tasks, LFSR stimulus,
// cycle-count timeout and error summary

`timescale 1ns/1ps

module fmul_tb;

  import fp_format_pkg::*;
  import fmul_ctrl_pkg::*;

  localparam int n_directed     = 33;   // Exact, rounding, specials, range, back-pressure
  localparam int n_rand         = 20;   // Per format
  localparam int n_trans        = n_directed + 2 * n_rand;
  localparam int reset_cycles   = 5;
  localparam int timeout_cycles = n_trans * 12 + reset_cycles;

  logic        clk, reset_n;
  logic        req, ack;
  fp_word_u    operand_a, operand_b, result;
  logic        fmt;                     // 1 double, 0 single
  round_mode_e rounding_mode;
  logic        flag_nv, flag_of, flag_uf, flag_nx;

  fp_word_u    got_word;                // Result captured at ack
  logic [3:0]  got_flags;               // {nv, of, uf, nx}
  logic [15:0] lfsr_state;
  int          mismatch_count = 0;
  int          other_count    = 0;
  int          cycle_count    = 0;

  tb_clock_gen u_clk (.clk, .reset_n);

  fmul_top dut (
    .clk, .reset_n, .req, .ack, .operand_a, .operand_b, .fmt, .rounding_mode,
    .result, .flag_nv, .flag_of, .flag_uf, .flag_nx
  );

  // ==============================
  // Helpers
  // ==============================
  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // Normal single widened to double, exact
  function automatic logic [63:0] sgl_to_dbl(input logic [31:0] s);
    return {s[31], {3'b000, s[30:23]} + 11'd896, s[22:0], 29'd0};
  endfunction

  // Double narrowed to single by round to nearest even, normal range only
  function automatic logic [31:0] dbl_to_sgl_rne(input logic [63:0] d);
    logic [10:0] e;
    logic [23:0] f;
    e = d[62:52] - 11'd896;
    f = {1'b0, d[51:29]};
    if (d[28] && ((|d[27:0]) || f[0])) f = f + 24'd1;  // Above half, or tie to even
    if (f[23]) e = e + 11'd1;                            // Fraction wrapped
    return {d[63], e[7:0], f[22:0]};
  endfunction

  // Exact 106-bit significand product has bits below the double fraction
  function automatic logic dbl_mul_inexact(input logic [63:0] a, input logic [63:0] b);
    logic [105:0] p;
    p = 106'({1'b1, a[51:0]}) * 106'({1'b1, b[51:0]});
    return p[105] ? (p[52:0] != '0) : (p[51:0] != '0);
  endfunction

  task automatic check_word(input string name, input fp_word_u got, input fp_word_u exp);
    if (got !== exp) begin
      $display("MISMATCH %s result: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flags(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s flags {nv,of,uf,nx}: got %h expected %h", name, got, exp);
      mismatch_count++;
    end
  endtask

  // ==============================
  // Four-phase transaction
  // ==============================
  task automatic do_mul(input logic f, input round_mode_e rm, input fp_word_u a,
                        input fp_word_u b, input int hold);
    int cycles;
    int k;
    @(posedge clk);
    req           <= 1'b1;
    operand_a     <= a;
    operand_b     <= b;
    fmt           <= f;
    rounding_mode <= rm;
    @(posedge clk);                     // Edge that sees req in idle
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);                   // Sample away from the edge
    end while (!ack && cycles < 16);
    if (cycles != 4 || !ack) begin
      $display("ack came %0d cycles after req was sampled, expected 4", cycles);
      other_count++;
    end
    got_word  = result;
    got_flags = {flag_nv, flag_of, flag_uf, flag_nx};
    for (k = 0; k < hold; k++) begin    // Back-pressure, req stays high
      @(posedge clk);
      @(negedge clk);
      if (!ack) begin
        $display("ack dropped while req was still high");
        other_count++;
      end
      check_word("held", result, got_word);
      check_flags("held", {flag_nv, flag_of, flag_uf, flag_nx}, got_flags);
    end
    @(posedge clk);
    req <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (ack && cycles < 8);
    if (ack || cycles != 1) begin
      $display("ack fell %0d cycles after req dropped, expected 1", cycles);
      other_count++;
    end
  endtask

  task automatic mul_check(input string name, input logic f, input round_mode_e rm,
                           input logic [63:0] a, input logic [63:0] b, input int hold,
                           input logic [63:0] exp_w, input logic [3:0] exp_fl);
    do_mul(f, rm, a, b, hold);
    check_word(name, got_word, exp_w);
    check_flags(name, got_flags, exp_fl);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_exact();
    mul_check("1.5*2.0 s", 1'b0, rm_rne, 64'hFFFFFFFF_3FC00000, 64'hFFFFFFFF_40000000, 0,
              64'hFFFFFFFF_40400000, 4'b0000);
    mul_check("-3.0*0.5 d", 1'b1, rm_rne, 64'hC008000000000000, 64'h3FE0000000000000, 0,
              64'hBFF8000000000000, 4'b0000);
  endtask

  // (1+2^-23)^2 sits just above an ulp, (1+2^-12)^2 is an exact tie on an even fraction
  task automatic test_rounding();
    round_mode_e modes   [5] = '{rm_rne, rm_rtz, rm_rdn, rm_rup, rm_rmm};
    logic [31:0] pos_exp [5] = '{32'h3F800002, 32'h3F800002, 32'h3F800002,
                                 32'h3F800003, 32'h3F800002};
    logic [31:0] neg_exp [5] = '{32'hBF800002, 32'hBF800002, 32'hBF800003,
                                 32'hBF800002, 32'hBF800002};
    logic [31:0] tie_exp [5] = '{32'h3F801000, 32'h3F801000, 32'h3F801000,
                                 32'h3F801001, 32'h3F801001};
    int i;
    for (i = 0; i < 5; i++) begin
      mul_check("round pos", 1'b0, modes[i], 64'hFFFFFFFF_3F800001, 64'hFFFFFFFF_3F800001,
                0, {32'hFFFFFFFF, pos_exp[i]}, 4'b0001);
      mul_check("round neg", 1'b0, modes[i], 64'hFFFFFFFF_BF800001, 64'hFFFFFFFF_3F800001,
                0, {32'hFFFFFFFF, neg_exp[i]}, 4'b0001);
      mul_check("round tie", 1'b0, modes[i], 64'hFFFFFFFF_3F800800, 64'hFFFFFFFF_3F800800,
                0, {32'hFFFFFFFF, tie_exp[i]}, 4'b0001);
    end
  endtask

  task automatic test_specials();
    mul_check("qnan s", 1'b0, rm_rne, 64'hFFFFFFFF_7FC00001, 64'hFFFFFFFF_3F800000, 0,
              64'hFFFFFFFF_7FC00000, 4'b1000);
    mul_check("snan d", 1'b1, rm_rne, 64'h7FF0000000000001, 64'h4000000000000000, 0,
              64'h7FF8000000000000, 4'b1000);
    mul_check("nan*0 s", 1'b0, rm_rne, 64'hFFFFFFFF_7F800001, 64'hFFFFFFFF_00000000, 0,
              64'hFFFFFFFF_7FC00000, 4'b1000);   // NaN wins over zero
    mul_check("0*inf d", 1'b1, rm_rne, 64'h0000000000000000, 64'h7FF0000000000000, 0,
              64'h7FF8000000000000, 4'b1000);
    mul_check("-inf*2 s", 1'b0, rm_rne, 64'hFFFFFFFF_FF800000, 64'hFFFFFFFF_40000000, 0,
              64'hFFFFFFFF_FF800000, 4'b0000);
    mul_check("-0*3 d", 1'b1, rm_rne, 64'h8000000000000000, 64'h4008000000000000, 0,
              64'h8000000000000000, 4'b0000);
    mul_check("sub*-2 s", 1'b0, rm_rne, 64'hFFFFFFFF_00000001, 64'hFFFFFFFF_C0000000, 0,
              64'hFFFFFFFF_80000000, 4'b0000);   // Subnormal reads as zero
  endtask

  task automatic test_range();
    mul_check("ovf d", 1'b1, rm_rne, 64'h7E70000000000000, 64'h7E70000000000000, 0,
              64'h7FF0000000000000, 4'b0101);    // 2^1000 squared
    mul_check("ovf s", 1'b0, rm_rne, 64'hFFFFFFFF_71800000, 64'hFFFFFFFF_F1800000, 0,
              64'hFFFFFFFF_FF800000, 4'b0101);
    mul_check("unf d", 1'b1, rm_rne, 64'h1A70000000000000, 64'h1A70000000000000, 0,
              64'h0000000000000000, 4'b0011);    // 2^-600 squared
    mul_check("unf s", 1'b0, rm_rne, 64'hFFFFFFFF_1C800000, 64'hFFFFFFFF_1C800000, 0,
              64'hFFFFFFFF_00000000, 4'b0011);
    // (1+u)(2-2u) rounds up across the binade to 2.0
    mul_check("carry s", 1'b0, rm_rne, 64'hFFFFFFFF_3F800001, 64'hFFFFFFFF_3FFFFFFE, 0,
              64'hFFFFFFFF_40000000, 4'b0001);
    mul_check("carry d", 1'b1, rm_rne, 64'h3FF0000000000001, 64'h3FFFFFFFFFFFFFFE, 0,
              64'h4000000000000000, 4'b0001);
  endtask

  task automatic test_backpressure();
    int hold;
    hold = 1 + int'(rand_bits(3));
    mul_check("bp s", 1'b0, rm_rne, 64'hFFFFFFFF_3FC00000, 64'hFFFFFFFF_40000000, hold,
              64'hFFFFFFFF_40400000, 4'b0000);
    hold = 1 + int'(rand_bits(3));
    mul_check("bp d", 1'b1, rm_rne, 64'hC008000000000000, 64'h3FE0000000000000, hold,
              64'hBFF8000000000000, 4'b0000);
    hold = 1 + int'(rand_bits(3));
    mul_check("bp ovf", 1'b1, rm_rne, 64'h7E70000000000000, 64'h7E70000000000000, hold,
              64'h7FF0000000000000, 4'b0101);
  endtask

  // ==============================
  // Random RNE products
  // ==============================
  task automatic test_random();
    logic        sg;
    logic [10:0] ed;
    logic [7:0]  es;
    logic [63:0] a, b, p;
    logic [31:0] sa, sb;
    int          i;
    for (i = 0; i < 2 * n_rand; i++) begin
      if (i < n_rand) begin             // Exponents within 2^+-256, product stays normal
        sg = 1'(rand_bits(1));
        ed = 11'd767 + 11'(rand_bits(9));
        a  = {sg, ed, 52'(rand_bits(52))};
        sg = 1'(rand_bits(1));
        ed = 11'd767 + 11'(rand_bits(9));
        b  = {sg, ed, 52'(rand_bits(52))};
        p  = $realtobits($bitstoreal(a) * $bitstoreal(b));
        mul_check("rand d", 1'b1, rm_rne, a, b, 0, p, {3'b000, dbl_mul_inexact(a, b)});
      end else begin                    // Exponents within 2^+-32
        sg = 1'(rand_bits(1));
        es = 8'd95 + 8'(rand_bits(6));
        sa = {sg, es, 23'(rand_bits(23))};
        sg = 1'(rand_bits(1));
        es = 8'd95 + 8'(rand_bits(6));
        sb = {sg, es, 23'(rand_bits(23))};
        p  = $realtobits($bitstoreal(sgl_to_dbl(sa)) * $bitstoreal(sgl_to_dbl(sb)));
        mul_check("rand s", 1'b0, rm_rne, {32'hFFFFFFFF, sa}, {32'hFFFFFFFF, sb}, 0,
                  {32'hFFFFFFFF, dbl_to_sgl_rne(p)}, {3'b000, |p[28:0]});
      end
    end
  endtask

  // ==============================
  // Run control
  // ==============================
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout after %0d cycles, tests did not complete", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr_state    = 16'd53905;
    req           = 1'b0;
    operand_a     = '0;
    operand_b     = '0;
    fmt           = 1'b0;
    rounding_mode = rm_rne;
    wait (reset_n === 1'b1);
    @(negedge clk);
    if (ack !== 1'b0) begin
      $display("ack is not low after reset");
      other_count++;
    end
    check_word("after reset", result, '0);
    check_flags("after reset", {flag_nv, flag_of, flag_uf, flag_nx}, 4'b0000);
    test_exact();
    test_rounding();
    test_specials();
    test_range();
    test_backpressure();
    test_random();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source
// 4 ns clock, active-low reset held for 5 cycles

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;           // 250 MHz
  end

  initial begin
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;                 // Released on an edge like all stimulus
  end

endmodule
